//--- tb.f
hdl/pit_pkg.sv
hdl/pit_axil_slave.sv
hdl/pit_regs.sv
hdl/pit_channel.sv
hdl/pit_top.sv
sim/pit_tb_assert.sv
sim/pit_tb.sv

//--- Makefile
# Verilator build and run of the interval timer testbench

VERILATOR ?= verilator
TOP       ?= pit_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+10
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIMARGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- sim/pit_tb.sv
`default_nettype none

module pit_tb;

	localparam int NTIMER = 4;
	localparam int CNT_W = 32;
	localparam int PERIOD = 20;
	localparam int TIMEOUT = 200;

	// channel settings
	localparam logic [31:0] AR_MAX = 32'd9;
	localparam logic [31:0] AR_ON = 32'd3;
	localparam logic [31:0] RUN_MAX = 32'd5000;
	localparam logic [31:0] OS_MAX = 32'd20;
	localparam logic [31:0] EXT_MAX = 32'd100;
	localparam int EXT_PULSES = 5;

	// control words
	localparam logic [31:0] C_LOAD = 32'(1 << pit_pkg::CTL_LOAD);
	localparam logic [31:0] C_EN = 32'(1 << pit_pkg::CTL_EN);
	localparam logic [31:0] C_AR = 32'(1 << pit_pkg::CTL_AR);
	localparam logic [31:0] C_XC = 32'(1 << pit_pkg::CTL_XC);
	localparam logic [31:0] C_GE = 32'(1 << pit_pkg::CTL_GE);

	integer seed = 32'ha81ee67d;

	logic clk_i;
	logic rst_i;
	logic [pit_pkg::ADDR_W-1:0] s_awaddr_i;
	logic s_awvalid_i;
	logic s_awready_o;
	logic [pit_pkg::DATA_W-1:0] s_wdata_i;
	logic [pit_pkg::DATA_W/8-1:0] s_wstrb_i;
	logic s_wvalid_i;
	logic s_wready_o;
	logic [1:0] s_bresp_o;
	logic s_bvalid_o;
	logic s_bready_i;
	logic [pit_pkg::ADDR_W-1:0] s_araddr_i;
	logic s_arvalid_i;
	logic s_arready_o;
	logic [pit_pkg::DATA_W-1:0] s_rdata_o;
	logic [1:0] s_rresp_o;
	logic s_rvalid_o;
	logic s_rready_i;
	logic [NTIMER-1:0] ext_clk_i;
	logic [NTIMER-1:0] gate_i;
	logic [NTIMER-1:0] out_o;
	logic irq_o;

	pit_top #(.NTIMER(NTIMER), .CNT_W(CNT_W)) dut_i (.*);

	initial clk_i = 1'b0;
	always #(PERIOD / 2) clk_i = ~clk_i;

	// ==============================
	// helpers
	// ==============================
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			stop_run($sformatf("mismatch at %0t: %s expected 0x%08h actual 0x%08h",
				$time, name, exp, got));
		end
	endtask

	function automatic logic [9:0] chan_addr(input int ch, input logic [3:0] off);
		return {ch[5:0], off};
	endfunction

	// ready stall of 0 to 3 cycles
	task automatic random_delay();
		int d;
		d = $unsigned($random(seed)) % 4;
		repeat (d) @(negedge clk_i);
	endtask

	// every bus task starts and ends just after a falling edge
	task automatic write_txn(input logic [9:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] resp);
		int n;
		s_awaddr_i = addr;
		s_wdata_i = data;
		s_wstrb_i = strb;
		s_awvalid_i = 1'b1;
		s_wvalid_i = 1'b1;
		n = 0;
		while (!s_awready_o) begin
			@(negedge clk_i);
			n++;
			if (n > TIMEOUT) stop_run("write address and data were never accepted");
		end
		// handshake happens at the coming rising edge
		@(negedge clk_i);
		s_awvalid_i = 1'b0;
		s_wvalid_i = 1'b0;
		n = 0;
		while (!s_bvalid_o) begin
			@(negedge clk_i);
			n++;
			if (n > TIMEOUT) stop_run("write response never became valid");
		end
		random_delay();
		check_value("s_bresp_o", {30'd0, resp}, {30'd0, s_bresp_o});
		s_bready_i = 1'b1;
		@(negedge clk_i);
		s_bready_i = 1'b0;
	endtask

	task automatic read_txn(input logic [9:0] addr, input logic [1:0] resp,
		output logic [31:0] data);
		int n;
		s_araddr_i = addr;
		s_arvalid_i = 1'b1;
		n = 0;
		while (!s_arready_o) begin
			@(negedge clk_i);
			n++;
			if (n > TIMEOUT) stop_run("read address was never accepted");
		end
		@(negedge clk_i);
		s_arvalid_i = 1'b0;
		n = 0;
		while (!s_rvalid_o) begin
			@(negedge clk_i);
			n++;
			if (n > TIMEOUT) stop_run("read data never became valid");
		end
		random_delay();
		check_value("s_rresp_o", {30'd0, resp}, {30'd0, s_rresp_o});
		data = s_rdata_o;
		s_rready_i = 1'b1;
		@(negedge clk_i);
		s_rready_i = 1'b0;
	endtask

	task automatic write_reg(input logic [9:0] addr, input logic [31:0] data);
		write_txn(addr, data, 4'hf, pit_pkg::RESP_OKAY);
	endtask

	task automatic expect_reg(input logic [9:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		read_txn(addr, pit_pkg::RESP_OKAY, got);
		check_value($sformatf("s_rdata_o at 0x%03h", addr), exp, got);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq_o !== level) begin
			@(negedge clk_i);
			n++;
			if (n > TIMEOUT) stop_run("irq_o never reached the expected level");
		end
	endtask

	// each pin pulse is two cycles high, two low
	task automatic pulse_ext(input int ch, input int count);
		repeat (count) begin
			ext_clk_i[ch] = 1'b1;
			repeat (2) @(negedge clk_i);
			ext_clk_i[ch] = 1'b0;
			repeat (2) @(negedge clk_i);
		end
	endtask

	// any bound assertion firing ends the run
	always @(negedge clk_i) begin
		if (dut_i.u_chk.failed) stop_run("a bus or timer assertion fired");
	end

	// ==============================
	// stimulus
	// ==============================
	initial begin
		logic [31:0] c_a;
		logic [31:0] c_b;
		logic [31:0] uf;
		rst_i = 1'b1;
		s_awaddr_i = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i = '0;
		s_wstrb_i = '0;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b0;
		s_araddr_i = '0;
		s_arvalid_i = 1'b0;
		s_rready_i = 1'b0;
		ext_clk_i = '0;
		gate_i = '0;
		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		@(negedge clk_i);

		// ch0 free runs to the end, watched by the period checks
		write_reg(chan_addr(0, pit_pkg::OFF_MAX), AR_MAX);
		write_reg(chan_addr(0, pit_pkg::OFF_ON), AR_ON);
		write_reg(chan_addr(0, pit_pkg::OFF_CTRL), C_LOAD | C_EN | C_AR);
		write_reg(pit_pkg::ADR_SYNC, 32'h1);

		// ch1 register readback, load reads as zero
		write_reg(chan_addr(1, pit_pkg::OFF_MAX), RUN_MAX);
		write_reg(chan_addr(1, pit_pkg::OFF_ON), 32'd100);
		write_reg(chan_addr(1, pit_pkg::OFF_CTRL), C_LOAD | C_EN | C_AR);
		write_reg(pit_pkg::ADR_SYNC, 32'h2);
		expect_reg(chan_addr(1, pit_pkg::OFF_CTRL), C_EN | C_AR);
		expect_reg(chan_addr(1, pit_pkg::OFF_MAX), RUN_MAX);
		read_txn(chan_addr(1, pit_pkg::OFF_COUNT), pit_pkg::RESP_OKAY, c_a);
		read_txn(chan_addr(1, pit_pkg::OFF_COUNT), pit_pkg::RESP_OKAY, c_b);
		assert (c_a <= RUN_MAX) else stop_run("channel 1 count read above its max");
		assert (c_b < c_a) else stop_run("channel 1 count did not decrease");

		// scratch, sync readback, map holes and partial strobes
		write_reg(pit_pkg::ADR_SCRATCH, 32'h5a5a_c3c3);
		expect_reg(pit_pkg::ADR_SCRATCH, 32'h5a5a_c3c3);
		expect_reg(pit_pkg::ADR_SYNC, 32'h0);
		read_txn(10'h100, pit_pkg::RESP_SLVERR, c_a);
		write_txn(10'h300, 32'h1, 4'hf, pit_pkg::RESP_SLVERR);
		write_txn(pit_pkg::ADR_SCRATCH, 32'h0, 4'h3, pit_pkg::RESP_SLVERR);
		expect_reg(pit_pkg::ADR_SCRATCH, 32'h5a5a_c3c3);

		// gate held low freezes ch1
		write_reg(chan_addr(1, pit_pkg::OFF_CTRL), C_EN | C_AR | C_GE);
		write_reg(pit_pkg::ADR_SYNC, 32'h2);
		read_txn(chan_addr(1, pit_pkg::OFF_COUNT), pit_pkg::RESP_OKAY, c_a);
		read_txn(chan_addr(1, pit_pkg::OFF_COUNT), pit_pkg::RESP_OKAY, c_b);
		check_value("gated count", c_a, c_b);

		// ch2 one-shot raises the interrupt
		write_reg(pit_pkg::ADR_IE, 32'h4);
		write_reg(chan_addr(2, pit_pkg::OFF_MAX), OS_MAX);
		write_reg(chan_addr(2, pit_pkg::OFF_ON), 32'd5);
		write_reg(chan_addr(2, pit_pkg::OFF_CTRL), C_LOAD | C_EN);
		write_reg(pit_pkg::ADR_SYNC, 32'h4);
		wait_irq(1'b1);
		read_txn(pit_pkg::ADR_UNDERFLOW, pit_pkg::RESP_OKAY, uf);
		check_value("underflow bit 2", 32'h4, uf & 32'h4);
		expect_reg(chan_addr(2, pit_pkg::OFF_COUNT), 32'd0);
		expect_reg(chan_addr(2, pit_pkg::OFF_COUNT), 32'd0);
		// enable cleared by the channel itself
		expect_reg(chan_addr(2, pit_pkg::OFF_CTRL), 32'd0);
		write_reg(pit_pkg::ADR_UNDERFLOW, uf);
		wait_irq(1'b0);

		// ch3 counts only external pin edges
		write_reg(chan_addr(3, pit_pkg::OFF_MAX), EXT_MAX);
		write_reg(chan_addr(3, pit_pkg::OFF_ON), 32'd50);
		write_reg(chan_addr(3, pit_pkg::OFF_CTRL), C_LOAD | C_EN | C_AR | C_XC);
		write_reg(pit_pkg::ADR_SYNC, 32'h8);
		expect_reg(chan_addr(3, pit_pkg::OFF_COUNT), EXT_MAX);
		pulse_ext(3, EXT_PULSES);
		// more than the 3 cycle synchronizer latency
		repeat (5) @(negedge clk_i);
		expect_reg(chan_addr(3, pit_pkg::OFF_COUNT), EXT_MAX - 32'(EXT_PULSES));

		// let ch0 run a few more periods
		repeat (40) @(negedge clk_i);
		if (dut_i.u_chk.failed) begin
			stop_run("a bus or timer assertion fired near the end");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/pit_tb_assert.sv
`default_nettype none

module pit_tb_assert #(
	parameter int NTIMER = 4,
	parameter int CNT_W = 32
) (
	input wire                          clk_i,
	input wire                          rst_i,
	input wire [pit_pkg::ADDR_W-1:0]    s_awaddr_i,
	input wire                          s_awvalid_i,
	input wire                          s_awready_o,
	input wire [pit_pkg::DATA_W-1:0]    s_wdata_i,
	input wire [pit_pkg::DATA_W/8-1:0]  s_wstrb_i,
	input wire                          s_wvalid_i,
	input wire                          s_wready_o,
	input wire [1:0]                    s_bresp_o,
	input wire                          s_bvalid_o,
	input wire                          s_bready_i,
	input wire                          s_arvalid_i,
	input wire                          s_arready_o,
	input wire [pit_pkg::DATA_W-1:0]    s_rdata_o,
	input wire [1:0]                    s_rresp_o,
	input wire                          s_rvalid_o,
	input wire                          s_rready_i,
	input wire [NTIMER-1:0]             out_o,
	input wire                          irq_o,
	// channel 0 shadow limits, the free running reference channel
	input wire [CNT_W-1:0]              max0_i,
	input wire [CNT_W-1:0]              on0_i
);

	logic failed = 1'b0;
	logic aw_hs;
	logic ar_hs;
	logic clr_hs;
	logic [NTIMER-1:0] ie_q;
	logic out0_q;
	logic rise0;
	logic fall0;
	logic seen_rise;
	logic [CNT_W-1:0] period_cnt;
	logic [CNT_W-1:0] high_cnt;

	assign aw_hs = s_awvalid_i & s_awready_o & s_wvalid_i & s_wready_o;
	assign ar_hs = s_arvalid_i & s_arready_o;
	// w1c write that clears every enabled underflow bit
	assign clr_hs = aw_hs && (&s_wstrb_i) && s_awaddr_i == pit_pkg::ADR_UNDERFLOW
		&& (ie_q & ~s_wdata_i[NTIMER-1:0]) == '0;
	assign rise0 = out_o[0] & ~out0_q;
	assign fall0 = ~out_o[0] & out0_q;

	// ==============================
	// bus and pin followers
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ie_q <= '0;
			out0_q <= 1'b0;
			seen_rise <= 1'b0;
			period_cnt <= '0;
			high_cnt <= '0;
		end else begin
			if (aw_hs && (&s_wstrb_i) && s_awaddr_i == pit_pkg::ADR_IE) begin
				ie_q <= s_wdata_i[NTIMER-1:0];
			end
			out0_q <= out_o[0];
			// cycles since the last rise of pin 0
			if (rise0) begin
				seen_rise <= 1'b1;
				period_cnt <= 32'd1;
			end else begin
				period_cnt <= period_cnt + 32'd1;
			end
			high_cnt <= out_o[0] ? high_cnt + 32'd1 : '0;
		end
	end

	// ==============================
	// checks
	// ==============================
	assert property (@(posedge clk_i) rst_i |=> !s_awready_o && !s_wready_o && !s_arready_o
		&& !s_bvalid_o && !s_rvalid_o && !irq_o && out_o == '0)
	else begin
		$error("bus or timer output active after reset");
		failed <= 1'b1;
	end

	// response held steady under back-pressure
	assert property (@(posedge clk_i) disable iff (rst_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
	else begin
		$error("write response dropped or changed while stalled");
		failed <= 1'b1;
	end

	assert property (@(posedge clk_i) disable iff (rst_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
	else begin
		$error("read response dropped or changed while stalled");
		failed <= 1'b1;
	end

	// valid rises one cycle after its handshake, and only then
	assert property (@(posedge clk_i) disable iff (rst_i) $rose(s_bvalid_o) == $past(aw_hs))
	else begin
		$error("write response not one cycle after the handshake");
		failed <= 1'b1;
	end

	assert property (@(posedge clk_i) disable iff (rst_i) $rose(s_rvalid_o) == $past(ar_hs))
	else begin
		$error("read response not one cycle after the handshake");
		failed <= 1'b1;
	end

	// auto-reload period is max plus one
	assert property (@(posedge clk_i) disable iff (rst_i)
		rise0 && seen_rise |-> period_cnt == max0_i + 32'd1)
	else begin
		$error("pin 0 period differs from max plus one");
		failed <= 1'b1;
	end

	assert property (@(posedge clk_i) disable iff (rst_i) fall0 |-> high_cnt == on0_i)
	else begin
		$error("pin 0 high time differs from the on-time");
		failed <= 1'b1;
	end

	assert property (@(posedge clk_i) disable iff (rst_i) $past(clr_hs, 2) |-> !irq_o)
	else begin
		$error("interrupt still high two cycles after the clear");
		failed <= 1'b1;
	end

endmodule

bind pit_top pit_tb_assert #(.NTIMER(NTIMER), .CNT_W(CNT_W)) u_chk (
	.*, .max0_i(max[0]), .on0_i(on[0])
);

`default_nettype wire

//--- hdl/pit_top.sv
`default_nettype none

module pit_top #(
	parameter int NTIMER = 4,
	parameter int CNT_W = 32
) (
	input  wire                            clk_i,
	input  wire                            rst_i,
	// axi4-lite slave
	input  wire [pit_pkg::ADDR_W-1:0]      s_awaddr_i,
	input  wire                            s_awvalid_i,
	output logic                           s_awready_o,
	input  wire [pit_pkg::DATA_W-1:0]      s_wdata_i,
	input  wire [pit_pkg::DATA_W/8-1:0]    s_wstrb_i,
	input  wire                            s_wvalid_i,
	output logic                           s_wready_o,
	output logic [1:0]                     s_bresp_o,
	output logic                           s_bvalid_o,
	input  wire                            s_bready_i,
	input  wire [pit_pkg::ADDR_W-1:0]      s_araddr_i,
	input  wire                            s_arvalid_i,
	output logic                           s_arready_o,
	output logic [pit_pkg::DATA_W-1:0]     s_rdata_o,
	output logic [1:0]                     s_rresp_o,
	output logic                           s_rvalid_o,
	input  wire                            s_rready_i,
	// timer pins, one bit per channel
	input  wire [NTIMER-1:0]               ext_clk_i,
	input  wire [NTIMER-1:0]               gate_i,
	output logic [NTIMER-1:0]              out_o,
	output logic                           irq_o
);

	// slave to register block
	logic wr;
	logic [pit_pkg::ADDR_W-1:0] wr_addr;
	logic [pit_pkg::DATA_W-1:0] wr_data;
	logic rd;
	logic [pit_pkg::ADDR_W-1:0] rd_addr;
	logic [pit_pkg::DATA_W-1:0] rd_data;
	logic [1:0] addr_err;

	// register block to channels
	logic [NTIMER-1:0] apply;
	logic [NTIMER-1:0][CNT_W-1:0] max;
	logic [NTIMER-1:0][CNT_W-1:0] on;
	logic [NTIMER-1:0][pit_pkg::CTL_W-1:0] ctl;
	logic [NTIMER-1:0][CNT_W-1:0] count;
	logic [NTIMER-1:0][pit_pkg::CTL_W-1:0] ctrl;
	logic [NTIMER-1:0] tc;

	pit_axil_slave u_slave (
		.clk_i, .rst_i,
		.s_awaddr_i, .s_awvalid_i, .s_awready_o,
		.s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
		.s_bresp_o, .s_bvalid_o, .s_bready_i,
		.s_araddr_i, .s_arvalid_i, .s_arready_o,
		.s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
		.wr_o(wr), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
		.rd_o(rd), .rd_addr_o(rd_addr), .rd_data_i(rd_data),
		.addr_err_i(addr_err)
	);

	pit_regs #(.NTIMER(NTIMER), .CNT_W(CNT_W)) u_regs (
		.clk_i, .rst_i,
		.wr_i(wr), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
		.rd_i(rd), .rd_addr_i(rd_addr), .rd_data_o(rd_data),
		.addr_err_o(addr_err),
		.apply_o(apply), .max_o(max), .on_o(on), .ctl_o(ctl),
		.count_i(count), .ctrl_i(ctrl), .tc_i(tc),
		.irq_o
	);

	// one counter per timer
	for (genvar i = 0; i < NTIMER; i++) begin : g_ch
		pit_channel #(.CNT_W(CNT_W)) u_ch (
			.clk_i, .rst_i,
			.ext_clk_i(ext_clk_i[i]), .gate_i(gate_i[i]),
			.apply_i(apply[i]), .max_i(max[i]), .on_i(on[i]), .ctl_i(ctl[i]),
			.count_o(count[i]), .ctrl_o(ctrl[i]), .tc_o(tc[i]), .out_o(out_o[i])
		);
	end

endmodule

`default_nettype wire

//--- hdl/pit_channel.sv
`default_nettype none

module pit_channel #(
	parameter int CNT_W = 32
) (
	input  wire                           clk_i,
	input  wire                           rst_i,
	// pins
	input  wire                           ext_clk_i,
	input  wire                           gate_i,
	// settings from the shadow registers
	input  wire                           apply_i,
	input  wire [CNT_W-1:0]               max_i,
	input  wire [CNT_W-1:0]               on_i,
	input  wire [pit_pkg::CTL_W-1:0]      ctl_i,
	// status
	output logic [CNT_W-1:0]              count_o,
	output logic [pit_pkg::CTL_W-1:0]     ctrl_o,
	output logic                          tc_o,
	output logic                          out_o
);

	// out of reset the channel is stopped but set to auto-reload
	localparam logic [pit_pkg::CTL_W-1:0] CTL_RST =
		{{(pit_pkg::CTL_W-1){1'b0}}, 1'b1} << pit_pkg::CTL_AR;

	logic [2:0] xsync_q;
	logic xpulse;
	logic [CNT_W-1:0] max_q;
	logic [CNT_W-1:0] on_q;
	logic ext_ok;
	logic gate_ok;
	logic advance;

	// ==============================
	// external clock
	// ==============================
	// two flops of synchronizer, the third holds the previous level
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			xsync_q <= '0;
		end else begin
			xsync_q <= {xsync_q[1:0], ext_clk_i};
		end
	end

	// rising edge, one clk_i cycle wide
	assign xpulse = xsync_q[1] & ~xsync_q[2];

	// count qualifiers
	assign ext_ok = ~ctrl_o[pit_pkg::CTL_XC] | xpulse;
	assign gate_ok = ~ctrl_o[pit_pkg::CTL_GE] | gate_i;
	assign advance = ctrl_o[pit_pkg::CTL_EN] & ext_ok & gate_ok;

	// active limits, only meaningful once applied
	always_ff @(posedge clk_i) begin
		if (apply_i) begin
			max_q <= max_i;
			on_q <= on_i;
		end
	end

	// ==============================
	// counter and output pin
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ctrl_o <= CTL_RST;
			count_o <= '0;
			tc_o <= 1'b0;
			out_o <= 1'b0;
		end else begin
			tc_o <= 1'b0;
			if (apply_i) begin
				ctrl_o <= ctl_i;
				// load never stays set in the active copy
				ctrl_o[pit_pkg::CTL_LOAD] <= 1'b0;
				if (ctl_i[pit_pkg::CTL_LOAD]) begin
					count_o <= max_i;
				end
			end else if (advance) begin
				if (count_o == '0) begin
					// terminal count
					tc_o <= 1'b1;
					out_o <= 1'b0;
					if (ctrl_o[pit_pkg::CTL_AR]) begin
						count_o <= max_q;
					end else begin
						// one-shot stops itself and parks at zero
						ctrl_o[pit_pkg::CTL_EN] <= 1'b0;
					end
				end else begin
					count_o <= count_o - 1'b1;
					// pin goes high for the last on_q counts of the period
					if (count_o == on_q) begin
						out_o <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/pit_regs.sv
`default_nettype none

module pit_regs #(
	parameter int NTIMER = 4,
	parameter int CNT_W = 32
) (
	input  wire                                         clk_i,
	input  wire                                         rst_i,
	// bus strobes
	input  wire                                         wr_i,
	input  wire [pit_pkg::ADDR_W-1:0]                   wr_addr_i,
	input  wire [pit_pkg::DATA_W-1:0]                   wr_data_i,
	input  wire                                         rd_i,
	input  wire [pit_pkg::ADDR_W-1:0]                   rd_addr_i,
	output logic [pit_pkg::DATA_W-1:0]                  rd_data_o,
	output logic [1:0]                                  addr_err_o,
	// shadows toward the channels
	output logic [NTIMER-1:0]                           apply_o,
	output logic [NTIMER-1:0][CNT_W-1:0]                max_o,
	output logic [NTIMER-1:0][CNT_W-1:0]                on_o,
	output logic [NTIMER-1:0][pit_pkg::CTL_W-1:0]       ctl_o,
	// channel status
	input  wire [NTIMER-1:0][CNT_W-1:0]                 count_i,
	input  wire [NTIMER-1:0][pit_pkg::CTL_W-1:0]        ctrl_i,
	input  wire [NTIMER-1:0]                            tc_i,
	output logic                                        irq_o
);

	localparam int AW = pit_pkg::ADDR_W;
	localparam int DW = pit_pkg::DATA_W;
	localparam int SH = pit_pkg::CH_STRIDE_SH;

	logic [NTIMER-1:0] uf_q;
	logic [NTIMER-1:0] ie_q;
	logic [DW-1:0] scratch_q;
	logic wr_uf;
	logic wr_sync;
	logic wr_ie;
	logic wr_scratch;
	logic wr_chan;
	logic rd_chan;
	int wr_ch;
	int rd_ch;
	logic [SH-1:0] wr_off;
	logic [SH-1:0] rd_off;

	// word compare, byte address bits are ignored
	function automatic logic is_reg(input logic [AW-1:0] a, input logic [AW-1:0] r);
		return a[AW-1:2] == r[AW-1:2];
	endfunction

	// valid = implemented channel window or the global block
	function automatic logic addr_bad(input logic [AW-1:0] a);
		logic glob;
		logic chan;
		glob = a[AW-1:SH] == pit_pkg::ADR_UNDERFLOW[AW-1:SH];
		chan = (a < pit_pkg::ADR_UNDERFLOW) && (int'(a >> SH) < NTIMER);
		return !(glob || chan);
	endfunction

	assign addr_err_o[pit_pkg::ERR_WR] = addr_bad(wr_addr_i);
	assign addr_err_o[pit_pkg::ERR_RD] = addr_bad(rd_addr_i);

	assign wr_uf = wr_i & is_reg(wr_addr_i, pit_pkg::ADR_UNDERFLOW);
	assign wr_sync = wr_i & is_reg(wr_addr_i, pit_pkg::ADR_SYNC);
	assign wr_ie = wr_i & is_reg(wr_addr_i, pit_pkg::ADR_IE);
	assign wr_scratch = wr_i & is_reg(wr_addr_i, pit_pkg::ADR_SCRATCH);

	assign wr_chan = wr_addr_i < pit_pkg::ADR_UNDERFLOW;
	assign rd_chan = rd_addr_i < pit_pkg::ADR_UNDERFLOW;
	assign wr_ch = int'(wr_addr_i >> SH);
	assign rd_ch = int'(rd_addr_i >> SH);
	assign wr_off = {wr_addr_i[SH-1:2], 2'b00};
	assign rd_off = {rd_addr_i[SH-1:2], 2'b00};

	// ==============================
	// shadows, sync, status
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			apply_o <= '0;
			max_o <= '0;
			on_o <= '0;
			ctl_o <= '0;
			uf_q <= '0;
			ie_q <= '0;
			irq_o <= 1'b0;
		end else begin
			// apply is a single cycle pulse per selected channel
			apply_o <= wr_sync ? wr_data_i[NTIMER-1:0] : '0;
			for (int n = 0; n < NTIMER; n++) begin
				// load request is consumed as the channel latches it
				if (apply_o[n]) begin
					ctl_o[n][pit_pkg::CTL_LOAD] <= 1'b0;
				end
				if (wr_i && wr_chan && wr_ch == n) begin
					case (wr_off)
						pit_pkg::OFF_MAX: max_o[n] <= wr_data_i[CNT_W-1:0];
						pit_pkg::OFF_ON: on_o[n] <= wr_data_i[CNT_W-1:0];
						pit_pkg::OFF_CTRL: ctl_o[n] <= wr_data_i[pit_pkg::CTL_W-1:0];
						// count is read only
						default: ;
					endcase
				end
			end
			// write one to clear, a fresh terminal count wins
			uf_q <= (uf_q & ~(wr_uf ? wr_data_i[NTIMER-1:0] : '0)) | tc_i;
			if (wr_ie) begin
				ie_q <= wr_data_i[NTIMER-1:0];
			end
			irq_o <= |(uf_q & ie_q);
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_scratch) begin
			scratch_q <= wr_data_i;
		end
	end

	// ==============================
	// read mux
	// ==============================
	always_comb begin
		rd_data_o = '0;
		if (rd_i) begin
			// sync register always reads back zero
			if (is_reg(rd_addr_i, pit_pkg::ADR_UNDERFLOW)) begin
				rd_data_o[NTIMER-1:0] = uf_q;
			end else if (is_reg(rd_addr_i, pit_pkg::ADR_IE)) begin
				rd_data_o[NTIMER-1:0] = ie_q;
			end else if (is_reg(rd_addr_i, pit_pkg::ADR_SCRATCH)) begin
				rd_data_o = scratch_q;
			end
			for (int n = 0; n < NTIMER; n++) begin
				if (rd_chan && rd_ch == n) begin
					case (rd_off)
						pit_pkg::OFF_COUNT: rd_data_o[CNT_W-1:0] = count_i[n];
						pit_pkg::OFF_MAX: rd_data_o[CNT_W-1:0] = max_o[n];
						pit_pkg::OFF_ON: rd_data_o[CNT_W-1:0] = on_o[n];
						// active bits, not the shadow
						default: rd_data_o[pit_pkg::CTL_W-1:0] = ctrl_i[n];
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/pit_axil_slave.sv
`default_nettype none

module pit_axil_slave (
	input  wire                            clk_i,
	input  wire                            rst_i,
	// write address
	input  wire [pit_pkg::ADDR_W-1:0]      s_awaddr_i,
	input  wire                            s_awvalid_i,
	output logic                           s_awready_o,
	// write data
	input  wire [pit_pkg::DATA_W-1:0]      s_wdata_i,
	input  wire [pit_pkg::DATA_W/8-1:0]    s_wstrb_i,
	input  wire                            s_wvalid_i,
	output logic                           s_wready_o,
	// write response
	output logic [1:0]                     s_bresp_o,
	output logic                           s_bvalid_o,
	input  wire                            s_bready_i,
	// read address
	input  wire [pit_pkg::ADDR_W-1:0]      s_araddr_i,
	input  wire                            s_arvalid_i,
	output logic                           s_arready_o,
	// read data
	output logic [pit_pkg::DATA_W-1:0]     s_rdata_o,
	output logic [1:0]                     s_rresp_o,
	output logic                           s_rvalid_o,
	input  wire                            s_rready_i,
	// register block side
	output logic                           wr_o,
	output logic [pit_pkg::ADDR_W-1:0]     wr_addr_o,
	output logic [pit_pkg::DATA_W-1:0]     wr_data_o,
	output logic                           rd_o,
	output logic [pit_pkg::ADDR_W-1:0]     rd_addr_o,
	input  wire [pit_pkg::DATA_W-1:0]      rd_data_i,
	input  wire [1:0]                      addr_err_i
);

	logic aw_rdy_q;
	logic ar_rdy_q;
	logic wr_hs;
	logic rd_hs;
	logic wr_ok;

	// shared ready for aw and w, the pair is accepted as one beat
	assign s_awready_o = aw_rdy_q;
	assign s_wready_o = aw_rdy_q;
	assign s_arready_o = ar_rdy_q;

	assign wr_hs = aw_rdy_q & s_awvalid_i & s_wvalid_i;
	assign rd_hs = ar_rdy_q & s_arvalid_i;

	// partial writes are refused, as are holes in the map
	assign wr_ok = (&s_wstrb_i) & ~addr_err_i[pit_pkg::ERR_WR];

	// decode sees the live address, valid holds it stable until accepted
	assign wr_addr_o = s_awaddr_i;
	assign wr_data_o = s_wdata_i;
	assign rd_addr_o = s_araddr_i;

	// strobes last exactly the handshake cycle
	assign wr_o = wr_hs & wr_ok;
	assign rd_o = rd_hs;

	// ==============================
	// write channel
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			aw_rdy_q <= 1'b0;
			s_bvalid_o <= 1'b0;
		end else begin
			// ready is a one cycle pulse, never while a response waits
			aw_rdy_q <= s_awvalid_i & s_wvalid_i & ~aw_rdy_q & ~s_bvalid_o;
			if (wr_hs) begin
				s_bvalid_o <= 1'b1;
			end else if (s_bvalid_o && s_bready_i) begin
				s_bvalid_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wr_hs) begin
			s_bresp_o <= wr_ok ? pit_pkg::RESP_OKAY : pit_pkg::RESP_SLVERR;
		end
	end

	// ==============================
	// read channel
	// ==============================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ar_rdy_q <= 1'b0;
			s_rvalid_o <= 1'b0;
		end else begin
			ar_rdy_q <= s_arvalid_i & ~ar_rdy_q & ~s_rvalid_o;
			if (rd_hs) begin
				s_rvalid_o <= 1'b1;
			end else if (s_rvalid_o && s_rready_i) begin
				s_rvalid_o <= 1'b0;
			end
		end
	end

	// data captured at the handshake edge and held until taken
	always_ff @(posedge clk_i) begin
		if (rd_hs) begin
			s_rdata_o <= rd_data_i;
			if (addr_err_i[pit_pkg::ERR_RD]) begin
				s_rresp_o <= pit_pkg::RESP_SLVERR;
			end else begin
				s_rresp_o <= pit_pkg::RESP_OKAY;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/pit_pkg.sv
`default_nettype none

package pit_pkg;

	// ==============================
	// bus geometry
	// ==============================
	localparam int ADDR_W = 10;
	localparam int DATA_W = 32;

	// each channel owns a 16 byte window
	localparam int CH_STRIDE_SH = 4;

	// offsets inside a channel window
	localparam logic [CH_STRIDE_SH-1:0] OFF_COUNT = 4'h0;
	localparam logic [CH_STRIDE_SH-1:0] OFF_MAX = 4'h4;
	localparam logic [CH_STRIDE_SH-1:0] OFF_ON = 4'h8;
	localparam logic [CH_STRIDE_SH-1:0] OFF_CTRL = 4'hc;

	// global registers, above the channel windows
	localparam logic [ADDR_W-1:0] ADR_UNDERFLOW = 10'h200;
	localparam logic [ADDR_W-1:0] ADR_SYNC = 10'h204;
	localparam logic [ADDR_W-1:0] ADR_IE = 10'h208;
	localparam logic [ADDR_W-1:0] ADR_SCRATCH = 10'h20c;

	// ==============================
	// control byte layout
	// ==============================
	localparam int CTL_W = 5;
	// load is a one-shot request, never held active
	localparam int CTL_LOAD = 0;
	localparam int CTL_EN = 1;
	localparam int CTL_AR = 2;
	localparam int CTL_XC = 3;
	localparam int CTL_GE = 4;

	// decode flag lanes, write address and read address
	localparam int ERR_WR = 0;
	localparam int ERR_RD = 1;

	// axi response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
